// ==== compile.f ====
+incdir+.
pipe_pkg.sv
pipe_ctrl.sv
fetch_queue.sv
stage_reg.sv
pipe_top.sv
tb_clock.sv
tb_checker.sv
pipe_properties.sv
tb_pipe.sv

// ==== Bender.yml ====
package:
  name: pipe_skeleton

export_include_dirs:
  - .

sources:
  - pipe_pkg.sv
  - pipe_ctrl.sv
  - fetch_queue.sv
  - stage_reg.sv
  - pipe_top.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_checker.sv
      - pipe_properties.sv
      - tb_pipe.sv

// ==== tb_pipe.sv ====
`timescale 1ns/1ps

module tb_pipe;
    localparam int num_cycles   = 3000;
    localparam int reset_cycles = 8;
    localparam int quiet_cycles = 15;  // first retirement plus eight consecutive tags
    localparam int clk_period   = 100;
    localparam int limit_cycles = num_cycles + 100;

    logic           clk;
    logic           rst_n;
    logic           i_cache_stall_req, d_cache_stall_req, forwardc_req, forwardp_req;
    logic           b_ctrl_flush_req, with_delayslot, exc_stall_req, exception_flush;
    logic           lsu1_tlb_stall_req, mem_refetch, fetch_exc;
    logic           wb_valid;
    logic           wb_exc;
    pipe_pkg::tag_t wb_tag;
    int             model_errors;
    int             order_errors;
    int             hold_errors;
    int             directed_errors = 0;
    logic [31:0]    rng_state;

    tb_clock #(.period(clk_period)) tb_clock_inst (.clk(clk));

    pipe_top pipe_top_inst (.*);

    tb_checker tb_checker_inst (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic rare_request();
        rng_state = xorshift(rng_state);
        return rng_state[2:0] == 3'd0;  // about one cycle in eight
    endfunction

    task automatic drive_inputs(input logic active);
        i_cache_stall_req  = active & rare_request();
        d_cache_stall_req  = active & rare_request();
        forwardc_req       = active & rare_request();
        forwardp_req       = active & rare_request();
        b_ctrl_flush_req   = active & rare_request();
        with_delayslot     = active & rng_state[16];
        exc_stall_req      = active & rare_request();
        exception_flush    = active & rare_request();
        lsu1_tlb_stall_req = active & rare_request();
        mem_refetch        = active & rare_request();
        fetch_exc          = active & rare_request();
    endtask

    task automatic check_first_retire();
        int waited;
        waited = 0;
        while (!wb_valid && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_valid || waited != 7 || wb_tag !== 0) begin
            $display("FAIL %0t: first retirement after %0d cycles with tag %0d, expected 7 and 0",
                     $time, waited, wb_tag);
            directed_errors++;
        end
        for (int k = 1; k <= 8; k++) begin
            @(negedge clk);
            if (!wb_valid || wb_tag !== pipe_pkg::tag_t'(k)) begin
                $display("FAIL %0t: retired tag %0d, expected %0d", $time, wb_tag, k);
                directed_errors++;
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        rng_state = 32'd3;
        drive_inputs(1'b0);
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        check_first_retire();
        repeat (num_cycles - reset_cycles - quiet_cycles) begin
            @(negedge clk);
            drive_inputs(1'b1);
        end
        @(negedge clk);
        drive_inputs(1'b0);
        @(negedge clk);
        $display("errors: model %0d, order %0d, hold %0d, directed %0d, assertion %0d",
                 model_errors, order_errors, hold_errors, directed_errors,
                 pipe_top_inst.pipe_properties_inst.assert_errors);
        if (model_errors + order_errors + hold_errors + directed_errors
            + pipe_top_inst.pipe_properties_inst.assert_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #(limit_cycles * clk_period);
        $display("watchdog expired before the test sequence finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== pipe_properties.sv ====
`timescale 1ns/1ps

`include "pipe_settings.svh"

module pipe_properties (
    input logic           clk,
    input logic           rst_n,
    input logic           d_cache_stall_req,
    input logic           exception_flush,
    input logic           mem_refetch,
    input logic           wb_valid,
    input pipe_pkg::tag_t wb_tag
);
    pipe_pkg::tag_t last_tag;
    logic           seen;
    int             assert_errors = 0;

    // last valid tag seen at wb, kept across bubbles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen     <= 1'b0;
            last_tag <= '0;
        end else if (wb_valid) begin
            seen     <= 1'b1;
            last_tag <= wb_tag;
        end
    end

    reset_clears_wb: assert property (@(posedge clk) !rst_n |-> !wb_valid)
        else begin
            $error("wb_valid is high while reset is asserted");
            assert_errors++;
        end

    stall_holds_tag: assert property (@(posedge clk) disable iff (!rst_n)
        (d_cache_stall_req && !exception_flush && !mem_refetch && wb_valid) |=> $stable(wb_tag))
        else begin
            $error("wb_tag moved during a data cache stall");
            assert_errors++;
        end

    // a held item gives a gap of zero, a new one a small forward step
    tags_increase: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_valid && seen) |->
            pipe_pkg::tag_t'(wb_tag - last_tag) < (1 << (`PIPE_TAG_W - 1)))
        else begin
            $error("retired tag went backwards");
            assert_errors++;
        end

endmodule

bind pipe_top pipe_properties pipe_properties_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .d_cache_stall_req (d_cache_stall_req),
    .exception_flush   (exception_flush),
    .mem_refetch       (mem_refetch),
    .wb_valid          (wb_valid),
    .wb_tag            (wb_tag)
);

// ==== tb_checker.sv ====
`timescale 1ns/1ps

`include "pipe_settings.svh"

module tb_checker (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           i_cache_stall_req,
    input  logic           d_cache_stall_req,
    input  logic           forwardc_req,
    input  logic           forwardp_req,
    input  logic           b_ctrl_flush_req,
    input  logic           with_delayslot,
    input  logic           exc_stall_req,
    input  logic           exception_flush,
    input  logic           lsu1_tlb_stall_req,
    input  logic           mem_refetch,
    input  logic           fetch_exc,
    input  logic           wb_valid,
    input  pipe_pkg::tag_t wb_tag,
    input  logic           wb_exc,
    output int             model_errors,
    output int             order_errors,
    output int             hold_errors
);
    pipe_pkg::tag_t pc;
    pipe_pkg::tag_t fq [$];  // queue contents with the head first
    logic           mv [7];  // index 0 is the queue head and 6 is wb
    pipe_pkg::tag_t mt [7];
    logic           me [7];
    logic           wb_loaded;
    logic           expect_hold;
    pipe_pkg::tag_t last_tag;
    pipe_pkg::tag_t prev_tag;
    logic           seen;
    logic           prev_valid;
    logic           prev_exc;

    always @(posedge clk or negedge rst_n) begin : step
        logic fwd, redir, pcs, fqf, iss, ld;
        logic stl [6];
        logic fl  [6];
        logic xfl [6];
        if (!rst_n) begin
            pc = '0;
            fq.delete();
            for (int i = 0; i < 7; i++) begin
                mv[i] = 1'b0;
                me[i] = 1'b0;
            end
            wb_loaded   = 1'b0;
            expect_hold = 1'b0;
        end else begin
            fwd   = forwardc_req | forwardp_req;
            redir = exception_flush | mem_refetch;
            pcs   = i_cache_stall_req | (fq.size() == `PIPE_FQ_DEPTH);
            fqf   = (b_ctrl_flush_req & ~fwd) | redir;
            iss   = d_cache_stall_req | fwd | exc_stall_req | lsu1_tlb_stall_req;
            stl[0] = iss | (pcs & fqf);
            fl[0]  = (b_ctrl_flush_req & ~fwd) | redir;
            stl[1] = d_cache_stall_req | exc_stall_req | lsu1_tlb_stall_req;
            fl[1]  = (b_ctrl_flush_req & with_delayslot) | fwd | redir;
            stl[2] = stl[1];
            fl[2]  = redir;
            stl[3] = d_cache_stall_req | exc_stall_req;
            fl[3]  = redir | lsu1_tlb_stall_req;
            stl[4] = d_cache_stall_req | (exc_stall_req & ~redir);
            fl[4]  = 1'b0;
            stl[5] = stl[4];
            fl[5]  = 1'b0;
            for (int i = 0; i < 6; i++) begin
                xfl[i] = (i < 4) ? redir : 1'b0;  // nothing past mem is cleared
            end
            mv[0] = (fq.size() != 0);
            mt[0] = mv[0] ? fq[0] : '0;
            me[0] = fetch_exc;
            // walk from wb backwards so each boundary still sees its old upstream
            for (int i = 5; i >= 0; i--) begin
                ld = ~stl[i] & ~fl[i];
                if (fl[i]) mv[i+1] = 1'b0;
                else if (ld) mv[i+1] = mv[i];
                if (xfl[i]) me[i+1] = 1'b0;
                else if (ld) me[i+1] = me[i];
                if (ld) mt[i+1] = mt[i];
            end
            if (fqf) begin
                fq.delete();
            end else begin
                if (!iss && fq.size() != 0) void'(fq.pop_front());
                if (!pcs) fq.push_back(pc);
            end
            if (!pcs) pc = pc + 1'b1;  // the tag is used up even when the queue drops it
            wb_loaded   = ~stl[5];
            expect_hold = d_cache_stall_req & ~redir;
        end
    end

    always @(negedge clk) begin : compare
        pipe_pkg::tag_t gap;
        if (!rst_n) begin
            seen       = 1'b0;
            prev_valid = 1'b0;
            prev_exc   = 1'b0;
        end else begin
            if (wb_valid !== mv[6] || (mv[6] && wb_tag !== mt[6]) || wb_exc !== me[6]) begin
                $display("FAIL %0t: wb %b/%0d/%b, model expects %b/%0d/%b", $time,
                         wb_valid, wb_tag, wb_exc, mv[6], mt[6], me[6]);
                model_errors++;
            end
            if (wb_valid && wb_loaded) begin
                gap = wb_tag - last_tag;  // modulo the tag width
                if (seen && (gap == 0 || gap >= (1 << (`PIPE_TAG_W - 1)))) begin
                    $display("FAIL %0t: tag %0d retired after tag %0d", $time, wb_tag, last_tag);
                    order_errors++;
                end
                last_tag = wb_tag;
                seen     = 1'b1;
            end
            if (expect_hold && (wb_valid !== prev_valid || wb_exc !== prev_exc
                                || (prev_valid && wb_tag !== prev_tag))) begin
                $display("FAIL %0t: wb changed during a data cache stall", $time);
                hold_errors++;
            end
            prev_valid = wb_valid;
            prev_tag   = wb_tag;
            prev_exc   = wb_exc;
        end
    end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 100
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

// ==== pipe_top.sv ====
`timescale 1ns/1ps

module pipe_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            i_cache_stall_req,
    input  logic            d_cache_stall_req,
    input  logic            forwardc_req,
    input  logic            forwardp_req,
    input  logic            b_ctrl_flush_req,
    input  logic            with_delayslot,
    input  logic            exc_stall_req,
    input  logic            exception_flush,
    input  logic            lsu1_tlb_stall_req,
    input  logic            mem_refetch,
    input  logic            fetch_exc,  // fetch fault on the item entering issue
    output logic            wb_valid,
    output pipe_pkg::tag_t  wb_tag,
    output logic            wb_exc
);
    logic fifo_stall_req, pc_stall, fifo_flush, issue_stall;
    logic ii_id2_flush, ii_id2_exception_flush, ii_id2_stall;
    logic id2_ex_flush, id2_ex_exception_flush, id2_ex_stall;
    logic ex_lsu1_flush, ex_lsu1_exp_flush, ex_lsu1_stall;
    logic lsu1_lsu2_flush, lsu1_lsu2_exp_flush, lsu1_lsu2_stall;
    logic mem_wb_flush, mem_wb_exception_flush, mem_wb_stall, wb_stall;

    pipe_pkg::tag_t pc_tag;
    pipe_pkg::tag_t head_tag;
    logic           head_valid;

    // six boundaries from issue to wb, index 0 is the queue head
    logic           v   [7];
    pipe_pkg::tag_t t   [7];
    logic           e   [7];
    logic           stl [6];
    logic           fl  [6];
    logic           xfl [6];

    pipe_ctrl pipe_ctrl_inst (.*);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_tag <= '0;
        end else if (!pc_stall) begin
            pc_tag <= pc_tag + 1'b1;  // one tag per fetch, in program order
        end
    end

    fetch_queue fetch_queue_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (~pc_stall),
        .push_tag       (pc_tag),
        .pop            (~issue_stall),
        .flush          (fifo_flush),
        .head_tag       (head_tag),
        .head_valid     (head_valid),
        .fifo_stall_req (fifo_stall_req)
    );

    assign v[0] = head_valid;
    assign t[0] = head_tag;
    assign e[0] = fetch_exc;

    assign stl = '{ii_id2_stall, id2_ex_stall, ex_lsu1_stall, lsu1_lsu2_stall,
                   mem_wb_stall, wb_stall};
    assign fl  = '{ii_id2_flush, id2_ex_flush, ex_lsu1_flush, lsu1_lsu2_flush,
                   mem_wb_flush, mem_wb_flush};  // wb reuses the mem_wb terms
    assign xfl = '{ii_id2_exception_flush, id2_ex_exception_flush, ex_lsu1_exp_flush,
                   lsu1_lsu2_exp_flush, mem_wb_exception_flush, mem_wb_exception_flush};

    // ii_id2, id2_ex, ex_lsu1, lsu1_lsu2, mem_wb, wb
    for (genvar i = 0; i < 6; i++) begin : g_stage
        stage_reg stage_reg_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .stall     (stl[i]),
            .flush     (fl[i]),
            .exp_flush (xfl[i]),
            .in_valid  (v[i]),
            .in_tag    (t[i]),
            .in_exc    (e[i]),
            .out_valid (v[i+1]),
            .out_tag   (t[i+1]),
            .out_exc   (e[i+1])
        );
    end

    assign wb_valid = v[6];
    assign wb_tag   = t[6];
    assign wb_exc   = e[6];

endmodule

// ==== stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            flush,
    input  logic            exp_flush,
    input  logic            in_valid,
    input  pipe_pkg::tag_t  in_tag,
    input  logic            in_exc,
    output logic            out_valid,
    output pipe_pkg::tag_t  out_tag,
    output logic            out_exc
);
    logic load;

    assign load = ~stall & ~flush;  // flush wins over stall and blocks the upstream item

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_exc   <= 1'b0;
        end else begin
            if (flush) begin
                out_valid <= 1'b0;
            end else if (load) begin
                out_valid <= in_valid;
            end
            // the pending flag is cleared on its own and valid is left alone
            if (exp_flush) begin
                out_exc <= 1'b0;
            end else if (load) begin
                out_exc <= in_exc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_tag <= in_tag;
        end
    end

endmodule

// ==== fetch_queue.sv ====
`timescale 1ns/1ps

`include "pipe_settings.svh"

module fetch_queue (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  pipe_pkg::tag_t  push_tag,
    input  logic            pop,
    input  logic            flush,
    output pipe_pkg::tag_t  head_tag,
    output logic            head_valid,
    output logic            fifo_stall_req
);
    pipe_pkg::tag_t    mem [`PIPE_FQ_DEPTH];
    pipe_pkg::fq_ptr_t wr_ptr;
    pipe_pkg::fq_ptr_t rd_ptr;
    pipe_pkg::fq_cnt_t count;
    logic              full;
    logic              do_push;
    logic              do_pop;

    assign full    = (count == pipe_pkg::fq_cnt_t'(`PIPE_FQ_DEPTH));
    assign do_push = push & ~full & ~flush;  // a flush also drops the tag fetched this cycle
    assign do_pop  = pop & head_valid & ~flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps with the power of two depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_tag;
        end
    end

    assign head_tag       = mem[rd_ptr];
    assign head_valid     = (count != '0);
    assign fifo_stall_req = full;  // holds the PC until issue drains an entry

endmodule

// ==== pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic i_cache_stall_req,
    input  logic d_cache_stall_req,
    input  logic fifo_stall_req,     // fetch queue full
    input  logic forwardc_req,
    input  logic forwardp_req,
    input  logic b_ctrl_flush_req,
    input  logic with_delayslot,     // branch resolved without a delay slot to keep
    input  logic exc_stall_req,
    input  logic exception_flush,
    input  logic lsu1_tlb_stall_req,
    input  logic mem_refetch,

    output logic pc_stall,
    output logic fifo_flush,
    output logic issue_stall,
    output logic ii_id2_flush,
    output logic ii_id2_exception_flush,
    output logic ii_id2_stall,
    output logic id2_ex_flush,
    output logic id2_ex_exception_flush,
    output logic id2_ex_stall,
    output logic ex_lsu1_flush,
    output logic ex_lsu1_exp_flush,
    output logic ex_lsu1_stall,
    output logic lsu1_lsu2_flush,
    output logic lsu1_lsu2_exp_flush,
    output logic lsu1_lsu2_stall,
    output logic mem_wb_flush,
    output logic mem_wb_exception_flush,
    output logic mem_wb_stall,
    output logic wb_stall
);
    logic fwd_req;
    logic redirect;

    assign fwd_req  = forwardc_req | forwardp_req;
    assign redirect = exception_flush | mem_refetch;  // everything younger than mem is dropped

    assign pc_stall    = i_cache_stall_req | fifo_stall_req;
    assign fifo_flush  = (b_ctrl_flush_req & ~fwd_req) | redirect;
    assign issue_stall = d_cache_stall_req | fwd_req | exc_stall_req | lsu1_tlb_stall_req;

    // a branch flush waits while a forwarding request still holds issue
    assign ii_id2_flush           = (b_ctrl_flush_req & ~fwd_req) | redirect;
    assign ii_id2_exception_flush = redirect;
    assign ii_id2_stall           = issue_stall | (pc_stall & fifo_flush) | fwd_req
                                  | exc_stall_req | lsu1_tlb_stall_req;

    // forwarding inserts a bubble into ex while decode holds
    assign id2_ex_flush           = (b_ctrl_flush_req & with_delayslot) | fwd_req | redirect;
    assign id2_ex_exception_flush = redirect;
    assign id2_ex_stall           = d_cache_stall_req | exc_stall_req | lsu1_tlb_stall_req;

    assign ex_lsu1_flush     = redirect;
    assign ex_lsu1_exp_flush = redirect;
    assign ex_lsu1_stall     = lsu1_tlb_stall_req | exc_stall_req | d_cache_stall_req;

    assign lsu1_lsu2_flush     = redirect | lsu1_tlb_stall_req;  // tlb miss leaves a bubble
    assign lsu1_lsu2_exp_flush = redirect;
    assign lsu1_lsu2_stall     = exc_stall_req | d_cache_stall_req;

    // the instruction in mem has already committed, so nothing past it is flushed
    assign mem_wb_flush           = 1'b0;
    assign mem_wb_exception_flush = 1'b0;

    assign mem_wb_stall = d_cache_stall_req | (exc_stall_req & ~redirect);
    assign wb_stall     = d_cache_stall_req | (exc_stall_req & ~redirect);

endmodule

// ==== pipe_pkg.sv ====
`include "pipe_settings.svh"

package pipe_pkg;

    // identifies one instruction in program order
    typedef logic [`PIPE_TAG_W-1:0] tag_t;

    // read and write pointers into the fetch queue
    typedef logic [`PIPE_FQ_PTR_W-1:0] fq_ptr_t;

    // occupancy count, one bit wider so that a full queue is representable
    typedef logic [`PIPE_FQ_PTR_W:0] fq_cnt_t;

endpackage

// ==== pipe_settings.svh ====
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// instruction tags wrap around after 256 fetches
`define PIPE_TAG_W 8

// fetch queue between the PC counter and issue
`define PIPE_FQ_DEPTH 4
`define PIPE_FQ_PTR_W 2  // log2 of the queue depth

`endif
